// File: verilog/pong_settings.svh
////////////////////////////////////////////////////////////
// playfield geometry and game constants, all in pixels
// ball coordinates are the top left corner of the ball
// right line and bottom wall already have the ball size removed
////////////////////////////////////////////////////////////

`ifndef PONG_SETTINGS_SVH
`define PONG_SETTINGS_SVH

`define PONG_BALL_SIZE     15
`define PONG_RACKET_HEIGHT 80
`define PONG_ZONE_UPPER    26
`define PONG_ZONE_MID      55
`define PONG_LEFT_LINE     100
`define PONG_RIGHT_LINE    898
`define PONG_TOP_WALL      51
`define PONG_BOTTOM_WALL   702
`define PONG_SPEED         10
`define PONG_X_CENTRE      504
`define PONG_Y_CENTRE      376
`define PONG_EDGE_LOW      11
`define PONG_EDGE_HIGH     1012
`define PONG_WIN_POINTS    10
`define PONG_POS_W         11
`define PONG_RACKET_W      10
`define PONG_POINTS_W      4

`endif

// File: verilog/pong_pkg.sv
////////////////////////////////////////////////////////////
// enums shared by the ball and score logic
// both types are 3 bits wide
////////////////////////////////////////////////////////////

package pong_pkg;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_SERVE  = 3'd1,
        ST_FLY    = 3'd2,
        ST_SCORED = 3'd3,
        ST_WIN    = 3'd4
    } game_state_e;

    // none means the ball stands still
    typedef enum logic [2:0] {
        DIR_NONE = 3'd0,
        DIR_SW   = 3'd1,
        DIR_W    = 3'd2,
        DIR_NW   = 3'd3,
        DIR_NE   = 3'd4,
        DIR_E    = 3'd5,
        DIR_SE   = 3'd6
    } flight_dir_e;

endpackage

// File: verilog/racket_check.sv
////////////////////////////////////////////////////////////
// purely combinational contact test at both racket lines
// a racket only reacts while the ball heads toward it
// bounce_dir is DIR_NONE away from the racket lines
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "pong_settings.svh"

module racket_check (
    input  logic [`PONG_POS_W-1:0]    ball_x,
    input  logic [`PONG_POS_W-1:0]    ball_y,
    input  pong_pkg::flight_dir_e     dir,
    input  logic [`PONG_RACKET_W-1:0] racket_right_y,
    input  logic [`PONG_RACKET_W-1:0] racket_left_y,
    output logic                      miss,
    output logic                      bounce,
    output pong_pkg::flight_dir_e     bounce_dir
);

    // one extra bit so the sums below never wrap
    localparam int CW = `PONG_POS_W + 1;

    logic          heading_east;
    logic          heading_west;
    logic          at_right;
    logic          at_left;
    logic          at_line;
    logic          outside;
    logic [CW-1:0] racket_top;
    logic [CW-1:0] contact_y;

    assign heading_east = (dir == pong_pkg::DIR_NE) || (dir == pong_pkg::DIR_E) ||
                          (dir == pong_pkg::DIR_SE);
    assign heading_west = (dir == pong_pkg::DIR_NW) || (dir == pong_pkg::DIR_W) ||
                          (dir == pong_pkg::DIR_SW);

    assign at_right = heading_east && (ball_x >= `PONG_RIGHT_LINE);
    assign at_left  = heading_west && (ball_x <= `PONG_LEFT_LINE);
    assign at_line  = at_right || at_left;

    // lower edge of the ball against the racket that faces it
    assign racket_top = at_right ? CW'(racket_right_y) : CW'(racket_left_y);
    assign contact_y  = CW'(ball_y) + CW'(`PONG_BALL_SIZE);
    assign outside    = (contact_y < racket_top) ||
                        (CW'(ball_y) > racket_top + CW'(`PONG_RACKET_HEIGHT));

    assign miss   = at_line && outside;
    assign bounce = at_line && !outside;

    // three racket zones
    always_comb begin
        if (!at_line) begin
            bounce_dir = pong_pkg::DIR_NONE;
        end else if (contact_y < racket_top + CW'(`PONG_ZONE_UPPER)) begin
            bounce_dir = at_right ? pong_pkg::DIR_NW : pong_pkg::DIR_NE;
        end else if (contact_y < racket_top + CW'(`PONG_ZONE_MID)) begin
            bounce_dir = at_right ? pong_pkg::DIR_W : pong_pkg::DIR_E;
        end else begin
            bounce_dir = at_right ? pong_pkg::DIR_SW : pong_pkg::DIR_SE;
        end
    end

endmodule

// File: verilog/ball_motion.sv
////////////////////////////////////////////////////////////
// ball position and heading, one step per end_of_frame
// end_of_frame pulses must be at least two cycles apart
// racket bounces are taken in ST_FLY only
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "pong_settings.svh"

module ball_motion (
    input  logic                   clk65MHz,
    input  logic                   rst,
    input  logic                   end_of_frame,
    input  pong_pkg::game_state_e  state,
    input  logic                   bounce,
    input  pong_pkg::flight_dir_e  bounce_dir,
    output logic [`PONG_POS_W-1:0] ball_x,
    output logic [`PONG_POS_W-1:0] ball_y,
    output pong_pkg::flight_dir_e  dir,
    output logic                   edge_reached
);

    localparam int POS_W = `PONG_POS_W;

    logic                  moving;
    logic                  step;
    logic                  between_lines;
    logic [POS_W-1:0]      next_x;
    logic [POS_W-1:0]      next_y;
    pong_pkg::flight_dir_e wall_dir;

    assign moving = (state == pong_pkg::ST_FLY) || (state == pong_pkg::ST_SCORED);

    // glide stop near the screen edge, the ball stays put on this frame
    assign edge_reached = (state == pong_pkg::ST_SCORED) && end_of_frame &&
                          ((ball_x > `PONG_EDGE_HIGH) || (ball_x < `PONG_EDGE_LOW));

    assign step          = moving && end_of_frame && !edge_reached;
    assign between_lines = (ball_x > `PONG_LEFT_LINE) && (ball_x < `PONG_RIGHT_LINE);

    ////////////////////////////////////////////////////////////
    // one step along the current heading
    always_comb begin
        case (dir)
            pong_pkg::DIR_NE, pong_pkg::DIR_E, pong_pkg::DIR_SE:
                next_x = ball_x + POS_W'(`PONG_SPEED);
            pong_pkg::DIR_NW, pong_pkg::DIR_W, pong_pkg::DIR_SW:
                next_x = ball_x - POS_W'(`PONG_SPEED);
            default:
                next_x = ball_x;
        endcase
        case (dir)
            pong_pkg::DIR_NE, pong_pkg::DIR_NW:
                next_y = ball_y - POS_W'(`PONG_SPEED);
            pong_pkg::DIR_SE, pong_pkg::DIR_SW:
                next_y = ball_y + POS_W'(`PONG_SPEED);
            default:
                next_y = ball_y;
        endcase
    end

    // top and bottom walls flip the vertical part only
    always_comb begin
        wall_dir = dir;
        if (between_lines && (ball_y <= `PONG_TOP_WALL)) begin
            if (dir == pong_pkg::DIR_NE) begin
                wall_dir = pong_pkg::DIR_SE;
            end else if (dir == pong_pkg::DIR_NW) begin
                wall_dir = pong_pkg::DIR_SW;
            end
        end else if (between_lines && (ball_y >= `PONG_BOTTOM_WALL)) begin
            if (dir == pong_pkg::DIR_SE) begin
                wall_dir = pong_pkg::DIR_NE;
            end else if (dir == pong_pkg::DIR_SW) begin
                wall_dir = pong_pkg::DIR_NW;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk65MHz) begin
        if (rst) begin
            ball_x <= POS_W'(`PONG_X_CENTRE);
            ball_y <= POS_W'(`PONG_Y_CENTRE);
            dir    <= pong_pkg::DIR_NONE;
        end else begin
            case (state)
                pong_pkg::ST_FLY, pong_pkg::ST_SCORED: begin
                    if (step) begin
                        ball_x <= next_x;
                        ball_y <= next_y;
                    end
                    if (bounce && (state == pong_pkg::ST_FLY)) begin
                        dir <= bounce_dir;
                    end else begin
                        dir <= wall_dir;
                    end
                end
                pong_pkg::ST_WIN: begin
                    ball_y <= '0;
                end
                pong_pkg::ST_SERVE: begin
                    ball_x <= POS_W'(`PONG_X_CENTRE);
                    ball_y <= POS_W'(`PONG_Y_CENTRE);
                    dir    <= pong_pkg::DIR_W;
                end
                default: begin
                    ball_x <= POS_W'(`PONG_X_CENTRE);
                    ball_y <= POS_W'(`PONG_Y_CENTRE);
                    dir    <= pong_pkg::DIR_NONE;
                end
            endcase
        end
    end

    // the glide stop keeps the ball inside the 1024 pixel line
    a_ball_x_on_screen: assert property (@(posedge clk65MHz) disable iff (rst)
        step |=> (ball_x < 1024));

endmodule

// File: verilog/game_fsm.sv
////////////////////////////////////////////////////////////
// five state game flow
// screen_idle overrides every other input
// a reached score limit wins from ST_SERVE without a serve
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module game_fsm (
    input  logic                  clk65MHz,
    input  logic                  rst,
    input  logic                  screen_idle,
    input  logic                  serve,
    input  logic                  miss,
    input  logic                  edge_reached,
    input  logic                  game_over,
    output pong_pkg::game_state_e state
);

    pong_pkg::game_state_e state_next;

    always_comb begin
        state_next = state;
        if (screen_idle) begin
            state_next = pong_pkg::ST_IDLE;
        end else begin
            case (state)
                pong_pkg::ST_IDLE: begin
                    state_next = pong_pkg::ST_SERVE;
                end
                pong_pkg::ST_SERVE: begin
                    if (game_over) begin
                        state_next = pong_pkg::ST_WIN;
                    end else if (serve) begin
                        state_next = pong_pkg::ST_FLY;
                    end
                end
                pong_pkg::ST_FLY: begin
                    if (miss) begin
                        state_next = pong_pkg::ST_SCORED;
                    end
                end
                // ball glides out until it hits the edge
                pong_pkg::ST_SCORED: begin
                    if (edge_reached) begin
                        state_next = pong_pkg::ST_SERVE;
                    end
                end
                pong_pkg::ST_WIN: begin
                    if (serve) begin
                        state_next = pong_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state_next = pong_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk65MHz) begin
        if (rst) begin
            state <= pong_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    a_win_after_serve: assert property (@(posedge clk65MHz) disable iff (rst)
        $rose(state == pong_pkg::ST_WIN) |-> ($past(state) == pong_pkg::ST_SERVE));

endmodule

// File: verilog/score_keeper.sv
////////////////////////////////////////////////////////////
// point counters for both players
// who_won lags the state by one cycle
// 1 means the right player won, 2 the left one
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "pong_settings.svh"

module score_keeper (
    input  logic                      clk65MHz,
    input  logic                      rst,
    input  pong_pkg::game_state_e     state,
    input  logic                      edge_reached,
    input  pong_pkg::flight_dir_e     dir,
    output logic [`PONG_POINTS_W-1:0] points_right,
    output logic [`PONG_POINTS_W-1:0] points_left,
    output logic                      game_over,
    output logic [1:0]                who_won
);

    localparam int PW = `PONG_POINTS_W;

    logic heading_west;
    logic point_scored;

    assign heading_west = (dir == pong_pkg::DIR_NW) || (dir == pong_pkg::DIR_W) ||
                          (dir == pong_pkg::DIR_SW);
    assign point_scored = (state == pong_pkg::ST_SCORED) && edge_reached;
    assign game_over    = (points_right >= PW'(`PONG_WIN_POINTS)) ||
                          (points_left >= PW'(`PONG_WIN_POINTS));

    // ball lost on the left side scores for the right player
    always_ff @(posedge clk65MHz) begin
        if (rst || (state == pong_pkg::ST_IDLE)) begin
            points_right <= '0;
            points_left  <= '0;
        end else if (point_scored && heading_west) begin
            points_right <= points_right + 1'b1;
        end else if (point_scored) begin
            points_left <= points_left + 1'b1;
        end
    end

    always_ff @(posedge clk65MHz) begin
        if (rst || (state != pong_pkg::ST_WIN)) begin
            who_won <= 2'd0;
        end else begin
            who_won <= (points_right > points_left) ? 2'd1 : 2'd2;
        end
    end

    a_score_limit: assert property (@(posedge clk65MHz) disable iff (rst)
        point_scored |=> (points_right <= `PONG_WIN_POINTS) &&
                         (points_left <= `PONG_WIN_POINTS));

endmodule

// File: verilog/pong_ball_top.sv
////////////////////////////////////////////////////////////
// ball and score logic of the two player paddle game
// end_of_frame is a one cycle pulse, at least two cycles apart
// serve and screen_idle are plain levels
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "pong_settings.svh"

module pong_ball_top (
    input  logic                      clk65MHz,
    input  logic                      rst,
    input  logic                      end_of_frame,
    input  logic                      serve,
    input  logic                      screen_idle,
    input  logic [`PONG_RACKET_W-1:0] racket_right_y,
    input  logic [`PONG_RACKET_W-1:0] racket_left_y,
    output logic [`PONG_POINTS_W-1:0] points_right,
    output logic [`PONG_POINTS_W-1:0] points_left,
    output logic [1:0]                who_won,
    output logic [`PONG_POS_W-1:0]    ball_x,
    output logic [`PONG_POS_W-1:0]    ball_y
);

    pong_pkg::game_state_e state;
    pong_pkg::flight_dir_e dir;
    pong_pkg::flight_dir_e bounce_dir;
    logic                  miss;
    logic                  bounce;
    logic                  edge_reached;
    logic                  game_over;

    game_fsm game_fsm_inst (
        .clk65MHz     (clk65MHz),
        .rst          (rst),
        .screen_idle  (screen_idle),
        .serve        (serve),
        .miss         (miss),
        .edge_reached (edge_reached),
        .game_over    (game_over),
        .state        (state)
    );

    ball_motion ball_motion_inst (
        .clk65MHz     (clk65MHz),
        .rst          (rst),
        .end_of_frame (end_of_frame),
        .state        (state),
        .bounce       (bounce),
        .bounce_dir   (bounce_dir),
        .ball_x       (ball_x),
        .ball_y       (ball_y),
        .dir          (dir),
        .edge_reached (edge_reached)
    );

    racket_check racket_check_inst (
        .ball_x         (ball_x),
        .ball_y         (ball_y),
        .dir            (dir),
        .racket_right_y (racket_right_y),
        .racket_left_y  (racket_left_y),
        .miss           (miss),
        .bounce         (bounce),
        .bounce_dir     (bounce_dir)
    );

    score_keeper score_keeper_inst (
        .clk65MHz     (clk65MHz),
        .rst          (rst),
        .state        (state),
        .edge_reached (edge_reached),
        .dir          (dir),
        .points_right (points_right),
        .points_left  (points_left),
        .game_over    (game_over),
        .who_won      (who_won)
    );

endmodule

// File: testbench/pong_ball_tb.sv
////////////////////////////////////////////////////////////
// testbench for pong_ball_top, driven line by line from a case file
// the case file path is relative to the project root
// every step ends with an output check on the falling edge
// end_of_frame pulses once every 8 cycles during frame steps
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "pong_settings.svh"

module pong_ball_tb;

    localparam int FRAME_CYCLES = 8;
    localparam int CLK_PERIOD   = 4;
    localparam int RW           = `PONG_RACKET_W;
    // room for reset, serve and check cycles on top of the frames
    localparam int SLACK_NS     = 2000;

    logic                      clk65MHz;
    logic                      rst;
    logic                      end_of_frame;
    logic                      serve;
    logic                      screen_idle;
    logic [`PONG_RACKET_W-1:0] racket_right_y;
    logic [`PONG_RACKET_W-1:0] racket_left_y;
    logic [`PONG_POINTS_W-1:0] points_right;
    logic [`PONG_POINTS_W-1:0] points_left;
    logic [1:0]                who_won;
    logic [`PONG_POS_W-1:0]    ball_x;
    logic [`PONG_POS_W-1:0]    ball_y;

    // one entry per usable case line
    logic [7:0] kind_q[$];
    int         line_q[$];
    int         right_q[$];
    int         left_q[$];
    int         count_q[$];
    int         exp_x_q[$];
    int         exp_y_q[$];
    int         exp_pr_q[$];
    int         exp_pl_q[$];
    int         exp_won_q[$];

    int   errors;
    int   checks;
    int   total_frames;
    logic armed;
    logic opened;

    pong_ball_top pong_ball_top_inst (
        .clk65MHz       (clk65MHz),
        .rst            (rst),
        .end_of_frame   (end_of_frame),
        .serve          (serve),
        .screen_idle    (screen_idle),
        .racket_right_y (racket_right_y),
        .racket_left_y  (racket_left_y),
        .points_right   (points_right),
        .points_left    (points_left),
        .who_won        (who_won),
        .ball_x         (ball_x),
        .ball_y         (ball_y)
    );

    ////////////////////////////////////////////////////////////
    // clock and watchdog

    initial begin
        clk65MHz = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk65MHz = ~clk65MHz;
        end
    end

    initial begin
        wait (armed);
        #(total_frames * FRAME_CYCLES * CLK_PERIOD + SLACK_NS);
        $display("watchdog expired at %0t ns before the last case line was done", $time);
        $display("Test FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // case file reader

    task automatic load_cases(output logic ok);
        int         fd;
        int         n;
        int         line_no;
        string      text;
        logic [7:0] kind;
        int         right_y;
        int         left_y;
        int         count;
        int         ex;
        int         ey;
        int         epr;
        int         epl;
        int         ewon;

        fd      = $fopen("testbench/pong_ball_cases.txt", "r");
        ok      = (fd != 0);
        line_no = 0;
        if (ok) begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                line_no++;
                // blank lines and column notes carry no step
                if ((n > 1) && (text.substr(0, 0) != "#")) begin
                    n = $sscanf(text, "%s %d %d %d %d %d %d %d %d", kind, right_y, left_y,
                                count, ex, ey, epr, epl, ewon);
                    if (n != 9) begin
                        $display("case line %0d is malformed, %0d of 9 fields were read",
                                 line_no, n);
                        errors++;
                    end else begin
                        kind_q.push_back(kind);
                        line_q.push_back(line_no);
                        right_q.push_back(right_y);
                        left_q.push_back(left_y);
                        count_q.push_back(count);
                        exp_x_q.push_back(ex);
                        exp_y_q.push_back(ey);
                        exp_pr_q.push_back(epr);
                        exp_pl_q.push_back(epl);
                        exp_won_q.push_back(ewon);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // steps, each one starts right on a rising edge

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (3) @(posedge clk65MHz);
        rst <= 1'b0;
        // one idle cycle, the FSM leaves ST_IDLE here
        @(posedge clk65MHz);
    endtask

    task automatic pulse_serve();
        serve <= 1'b1;
        @(posedge clk65MHz);
        serve <= 1'b0;
        @(posedge clk65MHz);
    endtask

    task automatic run_frames(input int count);
        repeat (count) begin
            end_of_frame <= 1'b1;
            @(posedge clk65MHz);
            end_of_frame <= 1'b0;
            repeat (FRAME_CYCLES - 1) @(posedge clk65MHz);
        end
    endtask

    task automatic report_mismatch(input int line_no, input string name, input int got,
                                   input int expected);
        errors++;
        $display("[FAIL] %s got 0x%0h expected 0x%0h at case line %0d",
                 name, got, expected, line_no);
    endtask

    // outputs are read half a cycle after the last edge of the step
    task automatic check_outputs(input int idx);
        @(negedge clk65MHz);
        checks++;
        if (int'(ball_x) != exp_x_q[idx]) begin
            report_mismatch(line_q[idx], "ball_x", int'(ball_x), exp_x_q[idx]);
        end
        if (int'(ball_y) != exp_y_q[idx]) begin
            report_mismatch(line_q[idx], "ball_y", int'(ball_y), exp_y_q[idx]);
        end
        if (int'(points_right) != exp_pr_q[idx]) begin
            report_mismatch(line_q[idx], "points_right", int'(points_right), exp_pr_q[idx]);
        end
        if (int'(points_left) != exp_pl_q[idx]) begin
            report_mismatch(line_q[idx], "points_left", int'(points_left), exp_pl_q[idx]);
        end
        if (int'(who_won) != exp_won_q[idx]) begin
            report_mismatch(line_q[idx], "who_won", int'(who_won), exp_won_q[idx]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    initial begin
        rst            <= 1'b1;
        end_of_frame   <= 1'b0;
        serve          <= 1'b0;
        screen_idle    <= 1'b0;
        racket_right_y <= '0;
        racket_left_y  <= '0;
        errors       = 0;
        checks       = 0;
        total_frames = 0;
        armed        = 1'b0;
        load_cases(opened);
        if (!opened) begin
            $display("cannot open testbench/pong_ball_cases.txt for reading");
            $display("Test FAILED");
            $finish;
        end else begin
            foreach (count_q[i]) begin
                total_frames += count_q[i];
            end
            armed = 1'b1;
            if (kind_q.size() == 0) begin
                $display("the case file holds no usable step lines");
                errors++;
            end
            for (int i = 0; i < kind_q.size(); i++) begin
                @(posedge clk65MHz);
                racket_right_y <= RW'(right_q[i]);
                racket_left_y  <= RW'(left_q[i]);
                case (kind_q[i])
                    "R": begin
                        apply_reset();
                        check_outputs(i);
                    end
                    "S": begin
                        pulse_serve();
                        check_outputs(i);
                    end
                    "F": begin
                        run_frames(count_q[i]);
                        check_outputs(i);
                    end
                    default: begin
                        $display("case line %0d has an unknown step kind", line_q[i]);
                        errors++;
                    end
                endcase
            end
            $display("%0d steps checked, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

// File: testbench/pong_ball_cases.txt
# kind right_y left_y frames exp_x exp_y exp_points_right exp_points_left exp_who_won
# kind R resets the DUT, S pulses serve and F runs the given number of frames
R 300 350  0 504 376  0 0 0
S 300 350  0 504 376  0 0 0
F 300 350 10 404 376  0 0 0
F 300 350 31  94 376  0 0 0
F 300 350  5 144 376  0 0 0
R 300 380  0 504 376  0 0 0
S 300 380  0 504 376  0 0 0
F 300 380 44 124 346  0 0 0
F 300 380 30 424  46  0 0 0
F 300 380  5 474  96  0 0 0
R 300 310  0 504 376  0 0 0
S 300 310  0 504 376  0 0 0
F 300 310 45 134 416  0 0 0
R 300 100  0 504 376  0 0 0
S 300 100  0 504 376  0 0 0
F 300 100 50   4 376  0 0 0
F 300 100  1 504 376  1 0 0
S 300 100  0 504 376  1 0 0
F 300 100 51 504 376  2 0 0
S 300 100  0 504 376  2 0 0
F 300 100 51 504 376  3 0 0
S 300 100  0 504 376  3 0 0
F 300 100 51 504 376  4 0 0
S 300 100  0 504 376  4 0 0
F 300 100 51 504 376  5 0 0
S 300 100  0 504 376  5 0 0
F 300 100 51 504 376  6 0 0
S 300 100  0 504 376  6 0 0
F 300 100 51 504 376  7 0 0
S 300 100  0 504 376  7 0 0
F 300 100 51 504 376  8 0 0
S 300 100  0 504 376  8 0 0
F 300 100 51 504 376  9 0 0
S 300 100  0 504 376  9 0 0
F 300 100 51 504   0 10 0 1
S 300 100  0 504 376  0 0 0

// File: sources.f
+incdir+verilog
verilog/pong_pkg.sv
verilog/racket_check.sv
verilog/ball_motion.sv
verilog/game_fsm.sv
verilog/score_keeper.sv
verilog/pong_ball_top.sv
testbench/pong_ball_tb.sv

// File: Makefile
# Verilator build and run for the paddle game ball logic

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pong_ball_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run passes only when the log holds the pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
